// File: hw/link_pkg.sv
//--------------------------------------------------------------------------
// Shared definitions for the single-clock link channel.
// Holds the sequencer state encoding and the default link constants.
// The top level takes its parameter defaults from here and passes them
// down to the sequencer, transmit and receive stages.
//--------------------------------------------------------------------------

package link_pkg;

  //--------------------------------------------------------------------------
  // sequencer states
  //--------------------------------------------------------------------------

  // post-reset bring-up phases of the master
  // seq_wait holds off after reset release
  // seq_prepare keeps the remote end in reset while both stages clear
  // seq_done is terminal, the link is calibrated
  typedef enum logic [1:0] {
    seq_wait    = 2'd0,
    seq_prepare = 2'd1,
    seq_done    = 2'd2
  } seq_state_e;

  //--------------------------------------------------------------------------
  // default link constants
  //--------------------------------------------------------------------------

  // width of one channel word
  localparam int link_width_c = 8;

  // log2 of the receive FIFO depth
  // the transmitter starts with this many credits
  localparam int link_lg_fifo_depth_c = 3;

  // log2 of credits carried by one token pulse
  // one token returns 2 words worth of space
  localparam int link_lg_decimation_c = 1;

  // cycles spent in seq_wait after reset release
  localparam int link_wait_cycles_c = 20;

  // cycles spent in seq_prepare before calibration is declared done
  // long enough for the remote end to see its reset
  localparam int link_prepare_cycles_c = 12;

endpackage

// File: hw/link_sequencer.sv
//--------------------------------------------------------------------------
// Link bring-up sequencer for the master side.
// After reset release it waits a fixed number of cycles, then holds a
// prepare window that resets the remote end and clears both stages,
// then declares calibration done and stays there until the next reset.
//--------------------------------------------------------------------------

module link_sequencer
  import link_pkg::*;
#(
  parameter int wait_cycles_p    = link_wait_cycles_c,
  parameter int prepare_cycles_p = link_prepare_cycles_c
) (
  input  logic io_master_clk_i,
  input  logic arst_n_i,
  output logic prepare_o,
  output logic calib_done_o
);

  // counter has to cover the longer of the two timed phases
  localparam int max_cycles_lp =
    (wait_cycles_p > prepare_cycles_p) ? wait_cycles_p : prepare_cycles_p;
  localparam int cnt_width_lp = (max_cycles_lp > 1) ? $clog2(max_cycles_lp + 1) : 1;

  // last count value of each phase
  localparam logic [cnt_width_lp-1:0] wait_last_lp    = cnt_width_lp'(wait_cycles_p - 1);
  localparam logic [cnt_width_lp-1:0] prepare_last_lp = cnt_width_lp'(prepare_cycles_p - 1);

  seq_state_e              state_r;
  seq_state_e              state_n;
  logic [cnt_width_lp-1:0] cnt_r;
  logic [cnt_width_lp-1:0] cnt_n;

  //--------------------------------------------------------------------------
  // next-state logic
  //--------------------------------------------------------------------------

  always_comb begin
    state_n = state_r;
    cnt_n   = cnt_r;
    case (state_r)
      seq_wait: begin
        // leave after exactly wait_cycles_p cycles in this state
        if (cnt_r == wait_last_lp) begin
          state_n = seq_prepare;
          cnt_n   = '0;
        end else begin
          cnt_n = cnt_r + 1'b1;
        end
      end
      seq_prepare: begin
        // remote reset window, same counting scheme
        if (cnt_r == prepare_last_lp) begin
          state_n = seq_done;
          cnt_n   = '0;
        end else begin
          cnt_n = cnt_r + 1'b1;
        end
      end
      seq_done: begin
        // terminal, counter parked at zero
        cnt_n = '0;
      end
      default: begin
        state_n = seq_wait;
        cnt_n   = '0;
      end
    endcase
  end

  //--------------------------------------------------------------------------
  // state and counter registers
  //--------------------------------------------------------------------------

  always_ff @(posedge io_master_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_r <= seq_wait;
      cnt_r   <= '0;
    end else begin
      state_r <= state_n;
      cnt_r   <= cnt_n;
    end
  end

  // outputs decode straight from the state register
  assign prepare_o    = (state_r == seq_prepare);
  assign calib_done_o = (state_r == seq_done);

endmodule

// File: hw/link_tx.sv
//--------------------------------------------------------------------------
// Transmit stage of the link channel.
// Core words are accepted under credit-based flow control and launched
// onto the outgoing wire one cycle later as a registered pulse. Credits
// start at the remote FIFO depth and come back in groups via token pulses.
//--------------------------------------------------------------------------

module link_tx
  import link_pkg::*;
#(
  parameter int channel_width_p = link_width_c,
  parameter int lg_fifo_depth_p = link_lg_fifo_depth_c,
  parameter int lg_decimation_p = link_lg_decimation_c
) (
  input  logic                       io_master_clk_i,
  input  logic                       arst_n_i,
  input  logic                       prepare_i,
  input  logic                       calib_done_i,
  input  logic                       core_valid_i,
  input  logic [channel_width_p-1:0] core_data_i,
  output logic                       core_ready_o,
  input  logic                       token_i,
  output logic                       tx_valid_o,
  output logic [channel_width_p-1:0] tx_data_o
);

  // one extra bit so a full count of 2^lg_fifo_depth_p fits
  localparam int credit_width_lp = lg_fifo_depth_p + 1;

  localparam logic [credit_width_lp-1:0] start_credits_lp =
    credit_width_lp'(1 << lg_fifo_depth_p);
  localparam logic [credit_width_lp-1:0] token_credits_lp =
    credit_width_lp'(1 << lg_decimation_p);

  logic [credit_width_lp-1:0] credits_r;
  logic [credit_width_lp-1:0] credits_n;
  logic                       accept;
  logic                       tx_valid_r;
  logic [channel_width_p-1:0] tx_data_r;

  //--------------------------------------------------------------------------
  // credit accounting
  //--------------------------------------------------------------------------

  // only send once bring-up is finished and the far FIFO has room
  assign core_ready_o = calib_done_i & (credits_r != '0);
  assign accept       = core_valid_i & core_ready_o;

  // a word and a token in the same cycle both count
  always_comb begin
    credits_n = credits_r;
    if (accept) begin
      credits_n = credits_n - 1'b1;
    end
    if (token_i) begin
      credits_n = credits_n + token_credits_lp;
    end
  end

  always_ff @(posedge io_master_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      credits_r  <= start_credits_lp;
      tx_valid_r <= 1'b0;
    end else if (prepare_i) begin
      // remote side is being reset, so all its slots are free again
      credits_r  <= start_credits_lp;
      tx_valid_r <= 1'b0;
    end else begin
      credits_r  <= credits_n;
      tx_valid_r <= accept;
    end
  end

  //--------------------------------------------------------------------------
  // outgoing wire
  //--------------------------------------------------------------------------

  // data only loads on an accepted word
  always_ff @(posedge io_master_clk_i) begin
    if (accept) begin
      tx_data_r <= core_data_i;
    end
  end

  assign tx_valid_o = tx_valid_r;
  assign tx_data_o  = tx_data_r;

endmodule

// File: hw/link_rx.sv
//--------------------------------------------------------------------------
// Receive stage of the link channel.
// Incoming wire words land in a circular FIFO that the core drains with
// a valid/yumi handshake. Every completed group of dequeues returns one
// token pulse to the far transmitter, which frees that many credits.
// The prepare level empties the FIFO and restarts the group count.
//--------------------------------------------------------------------------

module link_rx
  import link_pkg::*;
#(
  parameter int channel_width_p = link_width_c,
  parameter int lg_fifo_depth_p = link_lg_fifo_depth_c,
  parameter int lg_decimation_p = link_lg_decimation_c
) (
  input  logic                       io_master_clk_i,
  input  logic                       arst_n_i,
  input  logic                       prepare_i,
  input  logic                       rx_valid_i,
  input  logic [channel_width_p-1:0] rx_data_i,
  output logic                       core_valid_o,
  output logic [channel_width_p-1:0] core_data_o,
  input  logic                       core_yumi_i,
  output logic                       token_o
);

  localparam int depth_lp     = 1 << lg_fifo_depth_p;
  localparam int cnt_width_lp = lg_fifo_depth_p + 1;
  localparam int dec_width_lp = lg_decimation_p + 1;

  // count value of the last dequeue in a token group
  localparam logic [dec_width_lp-1:0] group_last_lp =
    dec_width_lp'((1 << lg_decimation_p) - 1);
  localparam logic [cnt_width_lp-1:0] full_cnt_lp = cnt_width_lp'(depth_lp);

  logic [channel_width_p-1:0] mem_r [depth_lp];
  logic [lg_fifo_depth_p-1:0] wr_ptr_r;
  logic [lg_fifo_depth_p-1:0] rd_ptr_r;
  logic [cnt_width_lp-1:0]    count_r;
  logic [dec_width_lp-1:0]    dec_cnt_r;
  logic                       token_r;
  logic                       full;
  logic                       wr_en;
  logic                       rd_en;

  //--------------------------------------------------------------------------
  // FIFO control
  //--------------------------------------------------------------------------

  assign full         = (count_r == full_cnt_lp);
  assign core_valid_o = (count_r != '0);
  assign core_data_o  = mem_r[rd_ptr_r];

  // words hitting a full FIFO are lost, credits should prevent that
  assign wr_en = rx_valid_i & ~full;
  assign rd_en = core_yumi_i & core_valid_o;

  always_ff @(posedge io_master_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else if (prepare_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      // pointers wrap naturally at the power-of-two depth
      if (wr_en) begin
        wr_ptr_r <= wr_ptr_r + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_r <= rd_ptr_r + 1'b1;
      end
      // simultaneous write and read leave the count alone
      if (wr_en && !rd_en) begin
        count_r <= count_r + 1'b1;
      end else if (rd_en && !wr_en) begin
        count_r <= count_r - 1'b1;
      end
    end
  end

  // storage array, written at the tail
  always_ff @(posedge io_master_clk_i) begin
    if (wr_en) begin
      mem_r[wr_ptr_r] <= rx_data_i;
    end
  end

  //--------------------------------------------------------------------------
  // token return
  //--------------------------------------------------------------------------

  always_ff @(posedge io_master_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dec_cnt_r <= '0;
      token_r   <= 1'b0;
    end else if (prepare_i) begin
      dec_cnt_r <= '0;
      token_r   <= 1'b0;
    end else if (rd_en) begin
      // pulse once per group of dequeues
      if (dec_cnt_r == group_last_lp) begin
        dec_cnt_r <= '0;
        token_r   <= 1'b1;
      end else begin
        dec_cnt_r <= dec_cnt_r + 1'b1;
        token_r   <= 1'b0;
      end
    end else begin
      token_r <= 1'b0;
    end
  end

  assign token_o = token_r;

endmodule

// File: hw/link_kernel.sv
//--------------------------------------------------------------------------
// Top level of the single-clock link channel, master side.
// Ties the bring-up sequencer to the transmit and receive stages. The
// wire and token loop between the stages is closed outside this module,
// so tx_* and token_o leave here and come back on rx_* and token_i.
//--------------------------------------------------------------------------

module link_kernel
  import link_pkg::*;
#(
  parameter int channel_width_p  = link_width_c,
  parameter int lg_fifo_depth_p  = link_lg_fifo_depth_c,
  parameter int lg_decimation_p  = link_lg_decimation_c,
  parameter int wait_cycles_p    = link_wait_cycles_c,
  parameter int prepare_cycles_p = link_prepare_cycles_c
) (
  input  logic                       io_master_clk_i,
  input  logic                       arst_n_i,

  // core in
  input  logic                       core_valid_i,
  input  logic [channel_width_p-1:0] core_data_i,
  output logic                       core_ready_o,

  // core out
  output logic                       core_valid_o,
  output logic [channel_width_p-1:0] core_data_o,
  input  logic                       core_yumi_i,

  // channel wire
  output logic                       tx_valid_o,
  output logic [channel_width_p-1:0] tx_data_o,
  input  logic                       rx_valid_i,
  input  logic [channel_width_p-1:0] rx_data_i,

  // credit tokens
  input  logic                       token_i,
  output logic                       token_o,

  // bring-up status
  output logic                       slave_reset_o,
  output logic                       calib_done_o
);

  logic prepare_lo;
  logic calib_done_lo;

  //--------------------------------------------------------------------------
  // bring-up control
  //--------------------------------------------------------------------------

  link_sequencer #(
    .wait_cycles_p   (wait_cycles_p),
    .prepare_cycles_p(prepare_cycles_p)
  ) u_sequencer (
    .io_master_clk_i(io_master_clk_i),
    .arst_n_i       (arst_n_i),
    .prepare_o      (prepare_lo),
    .calib_done_o   (calib_done_lo)
  );

  // remote end is held in reset for the whole prepare window
  assign slave_reset_o = prepare_lo;
  assign calib_done_o  = calib_done_lo;

  //--------------------------------------------------------------------------
  // data path stages
  //--------------------------------------------------------------------------

  link_tx #(
    .channel_width_p(channel_width_p),
    .lg_fifo_depth_p(lg_fifo_depth_p),
    .lg_decimation_p(lg_decimation_p)
  ) u_tx (
    .io_master_clk_i(io_master_clk_i),
    .arst_n_i       (arst_n_i),
    .prepare_i      (prepare_lo),
    .calib_done_i   (calib_done_lo),
    .core_valid_i   (core_valid_i),
    .core_data_i    (core_data_i),
    .core_ready_o   (core_ready_o),
    .token_i        (token_i),
    .tx_valid_o     (tx_valid_o),
    .tx_data_o      (tx_data_o)
  );

  link_rx #(
    .channel_width_p(channel_width_p),
    .lg_fifo_depth_p(lg_fifo_depth_p),
    .lg_decimation_p(lg_decimation_p)
  ) u_rx (
    .io_master_clk_i(io_master_clk_i),
    .arst_n_i       (arst_n_i),
    .prepare_i      (prepare_lo),
    .rx_valid_i     (rx_valid_i),
    .rx_data_i      (rx_data_i),
    .core_valid_o   (core_valid_o),
    .core_data_o    (core_data_o),
    .core_yumi_i    (core_yumi_i),
    .token_o        (token_o)
  );

endmodule

// File: test/link_kernel_tb_table.svh
//--------------------------------------------------------------------------
// Cycle table for the back-pressure and token return test.
// Starts from an empty FIFO with all credits home. Included inside the
// testbench module, fills the steps array row by row.
//--------------------------------------------------------------------------

`ifndef LINK_KERNEL_TB_TABLE_SVH
`define LINK_KERNEL_TB_TABLE_SVH

// columns: send, data, yumi, exp_ready, exp_valid, exp_data, exp_token
task automatic fill_table();
  // eight words use up every credit
  steps[0]  = '{1'b1, 8'h10, 1'b0, 1'b1, 1'b0, 8'h00, 1'b0};
  steps[1]  = '{1'b1, 8'h11, 1'b0, 1'b1, 1'b0, 8'h00, 1'b0};
  steps[2]  = '{1'b1, 8'h12, 1'b0, 1'b1, 1'b1, 8'h10, 1'b0};
  steps[3]  = '{1'b1, 8'h13, 1'b0, 1'b1, 1'b1, 8'h10, 1'b0};
  steps[4]  = '{1'b1, 8'h14, 1'b0, 1'b1, 1'b1, 8'h10, 1'b0};
  steps[5]  = '{1'b1, 8'h15, 1'b0, 1'b1, 1'b1, 8'h10, 1'b0};
  steps[6]  = '{1'b1, 8'h16, 1'b0, 1'b1, 1'b1, 8'h10, 1'b0};
  steps[7]  = '{1'b1, 8'h17, 1'b0, 1'b1, 1'b1, 8'h10, 1'b0};
  // no credits left, these sends are refused
  steps[8]  = '{1'b1, 8'h99, 1'b0, 1'b0, 1'b1, 8'h10, 1'b0};
  steps[9]  = '{1'b1, 8'h9a, 1'b0, 1'b0, 1'b1, 8'h10, 1'b0};
  steps[10] = '{1'b0, 8'h00, 1'b0, 1'b0, 1'b1, 8'h10, 1'b0};
  // two dequeues complete one token group
  steps[11] = '{1'b0, 8'h00, 1'b1, 1'b0, 1'b1, 8'h10, 1'b0};
  steps[12] = '{1'b0, 8'h00, 1'b1, 1'b0, 1'b1, 8'h11, 1'b0};
  steps[13] = '{1'b0, 8'h00, 1'b0, 1'b0, 1'b1, 8'h12, 1'b1};
  // two credits back, two words taken
  steps[14] = '{1'b1, 8'h20, 1'b0, 1'b1, 1'b1, 8'h12, 1'b0};
  steps[15] = '{1'b1, 8'h21, 1'b0, 1'b1, 1'b1, 8'h12, 1'b0};
  steps[16] = '{1'b1, 8'h22, 1'b0, 1'b0, 1'b1, 8'h12, 1'b0};
  steps[17] = '{1'b0, 8'h00, 1'b0, 1'b0, 1'b1, 8'h12, 1'b0};
  steps[18] = '{1'b0, 8'h00, 1'b0, 1'b0, 1'b1, 8'h12, 1'b0};
endtask

`endif

// File: test/link_kernel_tb.sv
//--------------------------------------------------------------------------
// Testbench for the single-clock link channel top level.
// Closes the wire and token loop outside the DUT, checks the bring-up
// timing, streams random words through the link against a model queue,
// then steps a cycle table through back-pressure and token return.
//--------------------------------------------------------------------------

module link_kernel_tb
  import link_pkg::*;
();

  localparam int stream_words_c = 24;
  localparam int num_steps_c    = 19;

  // one table row applied for one clock cycle
  typedef struct packed {
    logic       send;
    logic [7:0] data;
    logic       yumi;
    logic       exp_ready;
    logic       exp_valid;
    logic [7:0] exp_data;
    logic       exp_token;
  } step_t;

  logic       io_master_clk_i;
  logic       arst_n_i;
  logic       core_valid_i;
  logic [7:0] core_data_i;
  logic       core_ready_o;
  logic       core_valid_o;
  logic [7:0] core_data_o;
  logic       core_yumi_i;
  logic       tx_valid_o;
  logic [7:0] tx_data_o;
  logic       token_o;
  logic       slave_reset_o;
  logic       calib_done_o;

  step_t      steps [num_steps_c];
  logic [7:0] model_q [$];
  integer     seed = 26670;
  int         errors = 0;
  int         tests = 0;

  link_kernel uut (
    .io_master_clk_i(io_master_clk_i),
    .arst_n_i       (arst_n_i),
    .core_valid_i   (core_valid_i),
    .core_data_i    (core_data_i),
    .core_ready_o   (core_ready_o),
    .core_valid_o   (core_valid_o),
    .core_data_o    (core_data_o),
    .core_yumi_i    (core_yumi_i),
    .tx_valid_o     (tx_valid_o),
    .tx_data_o      (tx_data_o),
    .rx_valid_i     (tx_valid_o),
    .rx_data_i      (tx_data_o),
    .token_i        (token_o),
    .token_o        (token_o),
    .slave_reset_o  (slave_reset_o),
    .calib_done_o   (calib_done_o)
  );

  `include "link_kernel_tb_table.svh"

  // 100 unit clock period
  always #50 io_master_clk_i = ~io_master_clk_i;

  //--------------------------------------------------------------------------
  // check helpers
  //--------------------------------------------------------------------------

  task automatic expect_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    assert (got === exp) else begin
      $display("mismatch %s: got %0h expected %0h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  // timeouts end the run right away
  task automatic abort_on_timeout(input string what);
    $display("timeout while waiting for %s at %0t", what, $time);
    $display("Done: errors found");
    $finish;
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests++;
    $display("test %0d %s: %s", tests, name, (errors == errors_before) ? "ok" : "failed");
  endtask

  // step to the next drive point a small delay after the rising edge
  task automatic next_cycle();
    @(posedge io_master_clk_i);
    #10;
  endtask

  //--------------------------------------------------------------------------
  // test sequence
  //--------------------------------------------------------------------------

  initial begin
    int err0;
    int n;
    int sent;
    int got;
    logic [7:0] word;
    logic launched;

    io_master_clk_i = 1'b0;
    arst_n_i        = 1'b0;
    core_valid_i    = 1'b0;
    core_data_i     = '0;
    core_yumi_i     = 1'b0;
    fill_table();

    // reset and bring-up
    err0 = errors;
    repeat (16) @(posedge io_master_clk_i);
    expect_value("core_ready_o", core_ready_o, 0);
    expect_value("core_valid_o", core_valid_o, 0);
    expect_value("tx_valid_o", tx_valid_o, 0);
    expect_value("token_o", token_o, 0);
    expect_value("calib_done_o", calib_done_o, 0);
    expect_value("slave_reset_o", slave_reset_o, 0);
    #10;
    arst_n_i = 1'b1;
    n = 0;
    while (!slave_reset_o) begin
      next_cycle();
      n++;
      expect_value("core_ready_o", core_ready_o, 0);
      if (n > 200) abort_on_timeout("slave_reset_o to rise");
    end
    expect_value("wait cycles", n, link_wait_cycles_c);
    n = 0;
    while (slave_reset_o) begin
      next_cycle();
      n++;
      if (!calib_done_o) expect_value("core_ready_o", core_ready_o, 0);
      if (n > 200) abort_on_timeout("slave_reset_o to fall");
    end
    expect_value("prepare cycles", n, link_prepare_cycles_c);
    expect_value("calib_done_o", calib_done_o, 1);
    report_test("reset and bring-up", err0);

    // ready follows calibration
    err0 = errors;
    expect_value("core_ready_o", core_ready_o, 1);
    report_test("ready after calibration", err0);

    // random stream with a prompt consumer
    err0 = errors;
    sent = 0;
    got  = 0;
    n    = 0;
    while (got < stream_words_c) begin
      launched = 1'b0;
      if (sent < stream_words_c) begin
        word = 8'($random(seed));
        core_valid_i = 1'b1;
        core_data_i  = word;
        if (core_ready_o) begin
          model_q.push_back(word);
          sent++;
          launched = 1'b1;
        end
      end else begin
        core_valid_i = 1'b0;
      end
      core_yumi_i = core_valid_o;
      if (core_valid_o) begin
        assert (model_q.size() != 0) else begin
          $display("core_valid_o high with no word outstanding at %0t", $time);
          errors++;
        end
        if (model_q.size() != 0) begin
          expect_value("core_data_o", core_data_o, model_q.pop_front());
        end
        got++;
      end
      next_cycle();
      // an accepted word is on the wire for the cycle after the edge
      expect_value("tx_valid_o", tx_valid_o, launched);
      if (launched) expect_value("tx_data_o", tx_data_o, word);
      n++;
      if (n > 400) abort_on_timeout("stream words at core_data_o");
    end
    core_valid_i = 1'b0;
    core_yumi_i  = 1'b0;
    // let the last token come home
    n = 0;
    while (n < 4) begin
      next_cycle();
      n++;
    end
    expect_value("core_valid_o", core_valid_o, 0);
    expect_value("core_ready_o", core_ready_o, 1);
    report_test("data order", err0);

    // back-pressure and token return with one table row per cycle
    err0 = errors;
    for (int i = 0; i < num_steps_c; i++) begin
      core_valid_i = steps[i].send;
      core_data_i  = steps[i].data;
      core_yumi_i  = steps[i].yumi;
      #30;
      expect_value("core_ready_o", core_ready_o, steps[i].exp_ready);
      expect_value("core_valid_o", core_valid_o, steps[i].exp_valid);
      expect_value("token_o", token_o, steps[i].exp_token);
      if (steps[i].exp_valid) expect_value("core_data_o", core_data_o, steps[i].exp_data);
      next_cycle();
    end
    core_valid_i = 1'b0;
    core_yumi_i  = 1'b0;
    report_test("back-pressure and token return", err0);

    $display("tests run %0d, errors %0d", tests, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+test
hw/link_pkg.sv
hw/link_sequencer.sv
hw/link_tx.sv
hw/link_rx.sv
hw/link_kernel.sv
test/link_kernel_tb.sv

// File: Makefile
# Verilator build and run for the link channel testbench
# override any variable on the command line, e.g. make run LOG=out.log

VERILATOR ?= verilator
TOP       ?= link_kernel_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Done: errors found
VFLAGS    ?= --binary --timing

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) hw/*.sv test/*.sv test/*.svh
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# fails when the log holds the fail message or shows no result
run: compile
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q "Done: no errors" $(LOG) || (echo "no result in log"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
